//--- logic/fp_simd_pkg.sv
// Binary16 only, two lanes per 32-bit word, status reports NV alone and no rounding modes
`default_nettype none

package fp_simd_pkg;

  // --------------------
  // Format constants
  // --------------------
  localparam int unsigned WIDTH     = 32;
  localparam int unsigned FP_W      = 16;
  localparam int unsigned NUM_LANES = WIDTH / FP_W;
  localparam int unsigned TAG_W     = 4;

  // Quiet NaN with exponent all ones and mantissa MSB set
  localparam logic [FP_W-1:0] CANON_NAN = 16'h7E00;

  // Non-computational operations
  typedef enum logic [3:0] {
    SGNJ,
    SGNJN,
    SGNJX,
    FMIN,
    FMAX,
    FEQ,
    FLT,
    FLE,
    FCLASS
  } op_e;

  // IEEE exception flags, same order as fflags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // One-hot class, bit 0 first
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

  // Binary16 field layout
  typedef struct packed {
    logic       sign;
    logic [4:0] exponent;
    logic [9:0] mantissa;
  } fp16_t;

  // Raw bits for sign injection, fields for class and compare
  typedef union packed {
    logic [FP_W-1:0] raw;
    fp16_t           fields;
  } fp16_u;

endpackage

`default_nettype wire

//--- logic/fp_lane_if.sv
// One lane's request and response with valid/ready on both sides; no clock inside
`default_nettype none

interface fp_lane_if;
  import fp_simd_pkg::*;

  // Request side
  fp16_u              a;
  fp16_u              b;
  op_e                op;
  logic [TAG_W-1:0]   tag;
  logic               vec;
  logic               valid;
  logic               ready;

  // Response side
  logic [FP_W-1:0]    result;
  status_t            status;
  classmask_e         class_mask;
  logic               is_class;
  logic               ext_bit;
  logic [TAG_W-1:0]   tag_out;
  logic               vec_out;
  logic               out_valid;
  logic               out_ready;
  logic               busy;

  modport slice (
    output a, b, op, tag, vec, valid, out_ready,
    input  ready, result, status, class_mask, is_class, ext_bit, tag_out, vec_out,
    input  out_valid, busy
  );

  modport lane (
    input  a, b, op, tag, vec, valid, out_ready,
    output ready, result, status, class_mask, is_class, ext_bit, tag_out, vec_out,
    output out_valid, busy
  );

endinterface

`default_nettype wire

//--- logic/fp_noncomp_lane.sv
// Single register stage, one item in flight; min/max order -0 below +0, compares do not
`default_nettype none

module fp_noncomp_lane (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic flush_i,
  fp_lane_if.lane   lane_io
);
  import fp_simd_pkg::*;

  // Classify one operand through the field view
  function automatic classmask_e classify(fp16_u x);
    logic       exp_ones;
    logic       exp_zero;
    logic       man_zero;
    classmask_e cls;
    exp_ones = &x.fields.exponent;
    exp_zero = ~|x.fields.exponent;
    man_zero = ~|x.fields.mantissa;
    if (exp_ones && man_zero) begin
      cls = x.fields.sign ? NEGINF : POSINF;
    end else if (exp_ones) begin
      // Quiet bit is mantissa MSB
      cls = x.fields.mantissa[9] ? QNAN : SNAN;
    end else if (exp_zero && man_zero) begin
      cls = x.fields.sign ? NEGZERO : POSZERO;
    end else if (exp_zero) begin
      cls = x.fields.sign ? NEGSUBNORM : POSSUBNORM;
    end else begin
      cls = x.fields.sign ? NEGNORM : POSNORM;
    end
    return cls;
  endfunction

  // --------------------
  // Operand decode
  // --------------------
  fp16_u      a_u, b_u;
  classmask_e class_a, class_b;
  logic       a_nan, b_nan, any_nan, any_snan;
  logic       a_zero, b_zero;
  logic [14:0] mag_a, mag_b;
  logic       a_smaller, equal;

  assign a_u     = lane_io.a;
  assign b_u     = lane_io.b;
  assign class_a = classify(a_u);
  assign class_b = classify(b_u);

  assign a_nan    = (class_a == SNAN) || (class_a == QNAN);
  assign b_nan    = (class_b == SNAN) || (class_b == QNAN);
  assign any_nan  = a_nan | b_nan;
  assign any_snan = (class_a == SNAN) || (class_b == SNAN);
  assign a_zero   = (class_a == POSZERO) || (class_a == NEGZERO);
  assign b_zero   = (class_b == POSZERO) || (class_b == NEGZERO);

  assign mag_a = {a_u.fields.exponent, a_u.fields.mantissa};
  assign mag_b = {b_u.fields.exponent, b_u.fields.mantissa};

  // Total order with -0 below +0
  always_comb begin : order_cmp
    if (a_u.fields.sign != b_u.fields.sign) begin
      a_smaller = a_u.fields.sign;
    end else if (a_u.fields.sign) begin
      // Both negative, larger magnitude is smaller
      a_smaller = mag_a > mag_b;
    end else begin
      a_smaller = mag_a < mag_b;
    end
  end

  // IEEE equality, zeros equal regardless of sign
  assign equal = (a_u.raw == b_u.raw) || (a_zero && b_zero);

  // --------------------
  // Operation select
  // --------------------
  logic [FP_W-1:0] result_d;
  status_t         status_d;
  logic            ext_d;
  logic            is_class_d;

  always_comb begin : op_select
    result_d   = '0;
    status_d   = '0;
    ext_d      = 1'b0;
    is_class_d = 1'b0;
    case (lane_io.op)
      SGNJ: begin
        result_d = {b_u.raw[15], a_u.raw[14:0]};
        ext_d    = 1'b1;
      end
      SGNJN: begin
        result_d = {~b_u.raw[15], a_u.raw[14:0]};
        ext_d    = 1'b1;
      end
      SGNJX: begin
        result_d = {a_u.raw[15] ^ b_u.raw[15], a_u.raw[14:0]};
        ext_d    = 1'b1;
      end
      FMIN, FMAX: begin
        ext_d       = 1'b1;
        status_d.nv = any_snan;
        if (a_nan && b_nan) begin
          result_d = CANON_NAN;
        end else if (a_nan) begin
          // Single NaN yields the other operand
          result_d = b_u.raw;
        end else if (b_nan) begin
          result_d = a_u.raw;
        end else begin
          result_d = ((lane_io.op == FMIN) == a_smaller) ? a_u.raw : b_u.raw;
        end
      end
      FEQ: begin
        status_d.nv = any_snan;
        result_d[0] = ~any_nan & equal;
      end
      FLT: begin
        // Signaling compare, any NaN raises NV
        status_d.nv = any_nan;
        result_d[0] = ~any_nan & a_smaller & ~equal;
      end
      FLE: begin
        status_d.nv = any_nan;
        result_d[0] = ~any_nan & (a_smaller | equal);
      end
      FCLASS: begin
        result_d   = FP_W'(class_a);
        is_class_d = 1'b1;
      end
      default: begin
        result_d = '0;
      end
    endcase
  end

  // --------------------
  // Output register
  // --------------------
  logic             valid_q;
  logic             rdy_en_q;
  logic             lane_ready;
  logic             accept;
  logic [FP_W-1:0]  result_q;
  status_t          status_q;
  classmask_e       class_q;
  logic             is_class_q;
  logic             ext_q;
  logic [TAG_W-1:0] tag_q;
  logic             vec_q;

  // Empty or draining this cycle
  assign lane_ready = rdy_en_q & (~valid_q | lane_io.out_ready);
  assign accept     = lane_io.valid & lane_ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin : ctrl_regs
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      rdy_en_q <= 1'b0;
    end else begin
      // Ready comes up one cycle after reset release
      rdy_en_q <= 1'b1;
      if (flush_i) begin
        valid_q <= 1'b0;
      end else if (lane_ready) begin
        valid_q <= lane_io.valid;
      end
    end
  end

  // Payload held while stalled
  always_ff @(posedge clk_i) begin : data_regs
    if (accept) begin
      result_q   <= result_d;
      status_q   <= status_d;
      class_q    <= class_a;
      is_class_q <= is_class_d;
      ext_q      <= ext_d;
      tag_q      <= lane_io.tag;
      vec_q      <= lane_io.vec;
    end
  end

  assign lane_io.ready      = lane_ready;
  assign lane_io.out_valid  = valid_q;
  assign lane_io.busy       = valid_q;
  assign lane_io.result     = result_q;
  assign lane_io.status     = status_q;
  assign lane_io.class_mask = class_q;
  assign lane_io.is_class   = is_class_q;
  assign lane_io.ext_bit    = ext_q;
  assign lane_io.tag_out    = tag_q;
  assign lane_io.vec_out    = vec_q;

endmodule

`default_nettype wire

//--- logic/fp_simd_slice.sv
// Upper lane runs only in vector mode; scalar lane 0 inputs must be NaN-boxed or become qNaN
`default_nettype none

module fp_simd_slice (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_n_i,
  // Request
  input  wire logic [1:0][fp_simd_pkg::WIDTH-1:0]    operands_i,
  input  wire fp_simd_pkg::op_e                      op_i,
  input  wire logic                                  vectorial_op_i,
  input  wire logic [fp_simd_pkg::TAG_W-1:0]         tag_i,
  // Input handshake
  input  wire logic                                  in_valid_i,
  output logic                                       in_ready_o,
  input  wire logic                                  flush_i,
  // Response
  output logic [fp_simd_pkg::WIDTH-1:0]              result_o,
  output fp_simd_pkg::status_t                       status_o,
  output logic [fp_simd_pkg::TAG_W-1:0]              tag_o,
  // Output handshake
  output logic                                       out_valid_o,
  input  wire logic                                  out_ready_i,
  output logic                                       busy_o
);
  import fp_simd_pkg::*;

  fp_lane_if lane_if [NUM_LANES] ();

  logic                            result_is_vector;
  logic [NUM_LANES-1:0]            lane_out_valid;
  logic [NUM_LANES-1:0]            lane_busy;
  status_t [NUM_LANES-1:0]         lane_status;
  logic [NUM_LANES-1:0][FP_W-1:0]  slice_result;
  logic [NUM_LANES-1:0][7:0]       vec_class;
  logic [WIDTH-1:0]                class_result;

  // Vector flag of the item at the head of lane 0
  assign result_is_vector = lane_if[0].vec_out;

  // --------------------
  // Lanes
  // --------------------
  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane
    fp16_u [1:0] local_op;
    logic [9:0]  m;
    logic        neg;

    // Slice out lane operands, NaN-box check on scalar lane 0
    always_comb begin : lane_operands
      for (int i = 0; i < 2; i++) begin
        local_op[i].raw = operands_i[i][l*FP_W +: FP_W];
        if ((l == 0) && !vectorial_op_i && (operands_i[i][WIDTH-1:FP_W] != '1)) begin
          local_op[i].raw = CANON_NAN;
        end
      end
    end

    assign lane_if[l].a     = local_op[0];
    assign lane_if[l].b     = local_op[1];
    assign lane_if[l].op    = op_i;
    assign lane_if[l].tag   = tag_i;
    assign lane_if[l].vec   = vectorial_op_i;
    // Upper lane only takes vector requests
    assign lane_if[l].valid = in_valid_i & ((l == 0) | vectorial_op_i);

    fp_noncomp_lane lane_inst (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .flush_i (flush_i),
      .lane_io (lane_if[l].lane)
    );

    // Upper lane drains together with lane 0
    assign lane_if[l].out_ready = out_ready_i & ((l == 0) | result_is_vector);
    assign lane_out_valid[l]    = lane_if[l].out_valid & ((l == 0) | result_is_vector);
    assign lane_busy[l]         = lane_if[l].busy;

    // Unused lane is filled with lane 0's extension bit
    assign slice_result[l] = lane_out_valid[l] ? lane_if[l].result
                                               : {FP_W{lane_if[0].ext_bit}};
    assign lane_status[l]  = lane_out_valid[l] ? lane_if[l].status : '0;

    // 8-bit vector class block
    assign m   = lane_if[l].class_mask;
    assign neg = |m[3:0];
    assign vec_class[l] = {
      neg,          // negative
      ~neg,         // positive
      m[9],         // qnan
      m[8],         // snan
      m[3] | m[4],  // zero
      m[2] | m[5],  // subnormal
      m[1] | m[6],  // normal
      m[0] | m[7]   // inf
    };
  end

  // --------------------
  // Output side
  // --------------------
  assign in_ready_o = lane_if[0].ready;

  // Scalar class is the 10-bit mask zero-extended
  assign class_result = result_is_vector ? WIDTH'(vec_class) : WIDTH'(lane_if[0].class_mask);

  assign result_o    = lane_if[0].is_class ? class_result : slice_result;
  assign tag_o       = lane_if[0].tag_out;
  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_busy;

  // OR of gated lane flags
  always_comb begin : status_merge
    status_t acc;
    acc = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      acc = acc | lane_status[i];
    end
    status_o = acc;
  end

endmodule

`default_nettype wire

//--- logic/fp_simd_unit.sv
// Top level with plain ports, no added latency over the slice
`default_nettype none

module fp_simd_unit (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_n_i,
  // Request
  input  wire logic [1:0][fp_simd_pkg::WIDTH-1:0]    operands_i,
  input  wire fp_simd_pkg::op_e                      op_i,
  input  wire logic                                  vectorial_op_i,
  input  wire logic [fp_simd_pkg::TAG_W-1:0]         tag_i,
  // Input handshake
  input  wire logic                                  in_valid_i,
  output logic                                       in_ready_o,
  input  wire logic                                  flush_i,
  // Response
  output logic [fp_simd_pkg::WIDTH-1:0]              result_o,
  output fp_simd_pkg::status_t                       status_o,
  output logic [fp_simd_pkg::TAG_W-1:0]              tag_o,
  // Output handshake
  output logic                                       out_valid_o,
  input  wire logic                                  out_ready_i,
  output logic                                       busy_o
);

  fp_simd_slice slice_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .operands_i     (operands_i),
    .op_i           (op_i),
    .vectorial_op_i (vectorial_op_i),
    .tag_i          (tag_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .flush_i        (flush_i),
    .result_o       (result_o),
    .status_o       (status_o),
    .tag_o          (tag_o),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .busy_o         (busy_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
// Clock period 10, reset low for 8 rising edges and released on a falling edge
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/fp_simd_unit_tb.sv
// Self-checking against a binary16 reference model; stops at the first error, every wait bounded
`default_nettype none

module fp_simd_unit_tb;
  import fp_simd_pkg::*;

  logic                  clk;
  logic                  rst_n;
  logic [1:0][WIDTH-1:0] operands;
  op_e                   op;
  logic                  vec;
  logic [TAG_W-1:0]      tag_in;
  logic                  in_valid;
  logic                  in_ready;
  logic                  flush;
  logic [WIDTH-1:0]      result;
  status_t               status;
  logic [TAG_W-1:0]      tag_out;
  logic                  out_valid;
  logic                  out_ready;
  logic                  busy;

  // Expected responses in issue order
  logic [WIDTH-1:0]      exp_result_q[$];
  status_t               exp_status_q[$];
  logic [TAG_W-1:0]      exp_tag_q[$];

  integer                stim_seed  = 32'h9c63;
  integer                ready_seed = 32'h9c63;
  int                    ready_mode = 0;  // 0 always ready, 1 random, 2 stalled
  logic [TAG_W-1:0]      next_tag   = '0;
  logic [15:0]           specials [0:11];

  tb_clk_gen clk_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fp_simd_unit fp_simd_unit_inst (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .operands_i     (operands),
    .op_i           (op),
    .vectorial_op_i (vec),
    .tag_i          (tag_in),
    .in_valid_i     (in_valid),
    .in_ready_o     (in_ready),
    .flush_i        (flush),
    .result_o       (result),
    .status_o       (status),
    .tag_o          (tag_out),
    .out_valid_o    (out_valid),
    .out_ready_i    (out_ready),
    .busy_o         (busy)
  );

  // --------------------
  // Reference model
  // --------------------
  // Kind index inf 0, normal 1, subnormal 2, zero 3; positives mirror from bit 7 down
  function automatic logic [9:0] class_of(logic [15:0] h);
    logic [9:0] c;
    int         k;
    c = '0;
    if (h[14:10] == 5'h1F && h[9:0] != 0) begin
      c[h[9] ? 9 : 8] = 1'b1;
    end else begin
      if (h[14:10] == 5'h1F) k = 0;
      else if (h[14:10] != 0) k = 1;
      else if (h[9:0] != 0) k = 2;
      else k = 3;
      c[h[15] ? k : 7 - k] = 1'b1;
    end
    return c;
  endfunction

  // {negative, positive, qnan, snan, zero, subnormal, normal, inf}
  function automatic logic [7:0] class_block(logic [15:0] h);
    logic [7:0] blk;
    logic       nan;
    nan    = (h[14:10] == 5'h1F) && (h[9:0] != 0);
    blk[7] = h[15] && !nan;
    blk[6] = !blk[7];
    blk[5] = nan && h[9];
    blk[4] = nan && !h[9];
    blk[3] = (h[14:10] == 0) && (h[9:0] == 0);
    blk[2] = (h[14:10] == 0) && (h[9:0] != 0);
    blk[1] = (h[14:10] != 0) && (h[14:10] != 5'h1F);
    blk[0] = (h[14:10] == 5'h1F) && (h[9:0] == 0);
    return blk;
  endfunction

  // Monotonic key, -0 sorts just below +0
  function automatic logic [15:0] order_key(logic [15:0] h);
    return h[15] ? 16'h7FFF - {1'b0, h[14:0]} : 16'h8000 + {1'b0, h[14:0]};
  endfunction

  function automatic logic [15:0] lane_result(op_e o, logic [15:0] a, logic [15:0] b,
                                              output logic nv, output logic ext);
    logic [9:0]  ca;
    logic [9:0]  cb;
    logic        an;
    logic        bn;
    logic        both_zero;
    logic        lt;
    logic        eq;
    logic [15:0] r;
    ca        = class_of(a);
    cb        = class_of(b);
    an        = |ca[9:8];
    bn        = |cb[9:8];
    both_zero = (a[14:0] == 0) && (b[14:0] == 0);
    lt        = !both_zero && (order_key(a) < order_key(b));
    eq        = (a == b) || both_zero;
    r         = '0;
    nv        = 1'b0;
    ext       = 1'b0;
    case (o)
      SGNJ: begin
        r   = {b[15], a[14:0]};
        ext = 1'b1;
      end
      SGNJN: begin
        r   = {~b[15], a[14:0]};
        ext = 1'b1;
      end
      SGNJX: begin
        r   = {a[15] ^ b[15], a[14:0]};
        ext = 1'b1;
      end
      FMIN, FMAX: begin
        ext = 1'b1;
        nv  = ca[8] | cb[8];
        if (an && bn) r = CANON_NAN;
        else if (an) r = b;
        else if (bn) r = a;
        else if (o == FMIN) r = (order_key(a) < order_key(b)) ? a : b;
        else r = (order_key(a) > order_key(b)) ? a : b;
      end
      FEQ: begin
        nv   = ca[8] | cb[8];
        r[0] = !an && !bn && eq;
      end
      // Ordered compares signal on any NaN
      FLT: begin
        nv   = an | bn;
        r[0] = !an && !bn && lt;
      end
      FLE: begin
        nv   = an | bn;
        r[0] = !an && !bn && (lt || eq);
      end
      default: r = {6'b0, ca};
    endcase
    return r;
  endfunction

  function automatic logic [WIDTH-1:0] expect_word(logic [1:0][WIDTH-1:0] ops, op_e o,
                                                   logic v, output status_t st);
    logic [15:0] a0;
    logic [15:0] b0;
    logic [15:0] r0;
    logic [15:0] r1;
    logic        nv0;
    logic        nv1;
    logic        ext0;
    logic        ext1;
    a0 = ops[0][15:0];
    b0 = ops[1][15:0];
    // Scalar lane 0 needs a NaN-boxed operand
    if (!v && ops[0][31:16] != 16'hFFFF) a0 = CANON_NAN;
    if (!v && ops[1][31:16] != 16'hFFFF) b0 = CANON_NAN;
    r0 = lane_result(o, a0, b0, nv0, ext0);
    r1 = lane_result(o, ops[0][31:16], ops[1][31:16], nv1, ext1);
    st = '0;
    st.nv = v ? (nv0 | nv1) : nv0;
    if (o == FCLASS) begin
      return v ? {16'h0, class_block(ops[0][31:16]), class_block(a0)} : {22'h0, class_of(a0)};
    end
    return v ? {r1, r0} : {{16{ext0}}, r0};
  endfunction

  // --------------------
  // Error reporting
  // --------------------
  function automatic string mismatch_line(string what);
    return $sformatf("MISMATCH at time %0t: %s", $time, what);
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  // --------------------
  // Output monitor
  // --------------------
  logic             accepted_prev = 1'b0;
  logic             stalled_prev  = 1'b0;
  logic [WIDTH-1:0] held_result;
  status_t          held_status;
  logic [TAG_W-1:0] held_tag;

  always @(posedge clk) begin : monitor
    logic [WIDTH-1:0] exp_r;
    status_t          exp_s;
    logic [TAG_W-1:0] exp_t;
    if (rst_n) begin
      if (accepted_prev) begin
        assert (out_valid) else fail_run(mismatch_line("out_valid_o late after accept"));
      end
      // Stalled output must not move
      if (stalled_prev) begin
        assert (out_valid && result == held_result && status == held_status &&
                tag_out == held_tag)
          else fail_run(mismatch_line("output changed under back-pressure"));
      end
      if (out_valid && out_ready) begin
        assert (exp_result_q.size() > 0)
          else fail_run("output transfer appeared with no request pending");
        exp_r = exp_result_q.pop_front();
        exp_s = exp_status_q.pop_front();
        exp_t = exp_tag_q.pop_front();
        assert (result == exp_r)
          else fail_run(mismatch_line($sformatf("result %h, expected %h", result, exp_r)));
        assert (status == exp_s)
          else fail_run(mismatch_line($sformatf("status %b, expected %b", status, exp_s)));
        assert (tag_out == exp_t)
          else fail_run(mismatch_line($sformatf("tag %h, expected %h", tag_out, exp_t)));
      end
      stalled_prev = out_valid && !out_ready && !flush;
      held_result  = result;
      held_status  = status;
      held_tag     = tag_out;
      if (flush) begin
        exp_result_q.delete();
        exp_status_q.delete();
        exp_tag_q.delete();
      end
      accepted_prev = in_valid && in_ready && !flush;
      if (accepted_prev) begin
        exp_result_q.push_back(expect_word(operands, op, vec, exp_s));
        exp_status_q.push_back(exp_s);
        exp_tag_q.push_back(tag_in);
      end
    end
  end

  // Output back-pressure
  always @(negedge clk) begin : ready_drive
    case (ready_mode)
      0:       out_ready = 1'b1;
      1:       out_ready = ($random(ready_seed) & 3) != 0;
      default: out_ready = 1'b0;
    endcase
  end

  // --------------------
  // Stimulus helpers
  // --------------------
  function automatic logic [15:0] rand_half();
    if ($random(stim_seed) & 1) return specials[$unsigned($random(stim_seed)) % 12];
    return 16'($random(stim_seed));
  endfunction

  // Holds in_valid until the accepting edge
  task automatic send_req(input logic [1:0][WIDTH-1:0] ops, input op_e o, input logic v);
    int   wait_cycles;
    logic taken;
    @(negedge clk);
    operands = ops;
    op       = o;
    vec      = v;
    tag_in   = next_tag;
    in_valid = 1'b1;
    next_tag = next_tag + 1'b1;
    taken       = 1'b0;
    wait_cycles = 0;
    while (!taken) begin
      @(posedge clk);
      taken = in_ready;
      wait_cycles++;
      if (wait_cycles > 50) fail_run("timeout waiting for in_ready_o");
    end
  endtask

  task automatic drain();
    int wait_cycles;
    @(negedge clk);
    in_valid    = 1'b0;
    wait_cycles = 0;
    while (exp_result_q.size() != 0 || busy) begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > 200) fail_run("timeout waiting for pending results to drain");
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin : main
    int                    wait_cycles;
    logic [1:0][WIDTH-1:0] ops;
    logic                  v;
    operands  = '0;
    op        = SGNJ;
    vec       = 1'b0;
    tag_in    = '0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b1;
    specials  = '{16'h0000, 16'h8000, 16'h7C00, 16'hFC00, 16'h7E00, 16'h7C01,
                  16'hFD00, 16'h0001, 16'h8200, 16'h3C00, 16'hC000, 16'h7BFF};

    // Reset holds outputs low, sampled on rising edges
    wait_cycles = 0;
    do begin
      @(posedge clk);
      if (!rst_n) begin
        assert (!out_valid && !busy && !in_ready)
          else fail_run(mismatch_line("outputs active during reset"));
      end
      wait_cycles++;
      if (wait_cycles > 20) fail_run("timeout waiting for reset release");
    end while (!rst_n);
    @(negedge clk);
    assert (in_ready) else fail_run(mismatch_line("in_ready_o low one cycle after reset"));

    // Scalar directed, all special pairs
    for (int o = 0; o < 9; o++) begin
      for (int i = 0; i < 12; i++) begin
        for (int j = 0; j < 12; j++) begin
          send_req({16'hFFFF, specials[j], 16'hFFFF, specials[i]}, op_e'(o), 1'b0);
        end
      end
      // Unboxed first operand
      send_req({16'hFFFF, 16'h3C00, 16'h1234, 16'h4000}, op_e'(o), 1'b0);
    end
    drain();

    // Vector directed with different values per lane
    for (int o = 0; o < 9; o++) begin
      for (int i = 0; i < 12; i++) begin
        ops = {specials[(i * 7) % 12], specials[(i + 3) % 12],
               specials[(i + 5) % 12], specials[i]};
        send_req(ops, op_e'(o), 1'b1);
      end
    end
    drain();

    // Random mix under back-pressure
    ready_mode = 1;
    for (int n = 0; n < 600; n++) begin
      v   = $random(stim_seed) & 1;
      ops = {rand_half(), rand_half(), rand_half(), rand_half()};
      if (!v && ($random(stim_seed) & 7) != 0) begin
        ops[0][31:16] = 16'hFFFF;
        ops[1][31:16] = 16'hFFFF;
      end
      send_req(ops, op_e'($unsigned($random(stim_seed)) % 9), v);
    end
    drain();

    // Flush drops a stalled item
    ready_mode = 2;
    repeat (2) @(negedge clk);
    send_req({16'h7C01, 16'h3C00, 16'hC000, 16'h0001}, FMAX, 1'b1);
    @(negedge clk);
    in_valid = 1'b0;
    assert (out_valid && busy) else fail_run(mismatch_line("item not in flight before flush"));
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    assert (!out_valid && !busy)
      else fail_run(mismatch_line("flush left an item in flight"));
    ready_mode = 0;
    repeat (4) @(negedge clk);

    if (exp_result_q.size() == 0 && !busy) begin
      $display("Verification passed");
    end else begin
      fail_run("results still pending at end of run");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: fp_simd_unit

sources:
  # Package and interface first, then the lane, slice and top
  - logic/fp_simd_pkg.sv
  - logic/fp_lane_if.sv
  - logic/fp_noncomp_lane.sv
  - logic/fp_simd_slice.sv
  - logic/fp_simd_unit.sv

  - target: simulation
    files:
      - tb/tb_clk_gen.sv
      - tb/fp_simd_unit_tb.sv

//--- src.f
logic/fp_simd_pkg.sv
logic/fp_lane_if.sv
logic/fp_noncomp_lane.sv
logic/fp_simd_slice.sv
logic/fp_simd_unit.sv
tb/tb_clk_gen.sv
tb/fp_simd_unit_tb.sv
